// ==== logic/dist_defines.svh ====
`ifndef DIST_DEFINES_SVH
`define DIST_DEFINES_SVH

//////////////////////////////////////////////////
// sizing of the distribution subsystem
//////////////////////////////////////////////////

// data word carried by one packet
`define DIST_DATA_WIDTH 16

// PEs in the array, one chain stage each
`define DIST_NUM_NODE 8

// accumulator width, sums wrap at this width
`define DIST_SUM_WIDTH 24

// entries in the input FIFO
`define DIST_QUEUE_DEPTH 4

`endif

// ==== logic/dist_pkg.sv ====
`include "dist_defines.svh"

package dist_pkg;

	//////////////////////////////////////////////////
	// packet types
	//////////////////////////////////////////////////

	// destination tag, holds any node index
	typedef logic [$clog2(`DIST_NUM_NODE)-1:0] dest_t;

	// tag in the upper bits, word below
	typedef struct packed
	{
		dest_t                       dest;
		logic [`DIST_DATA_WIDTH-1:0] data;
	} dist_packet_t;

endpackage

// ==== logic/packet_queue.sv ====
`timescale 1ns/1ps
`include "dist_defines.svh"

module packet_queue
	import dist_pkg::*;
(
	input  logic         CLK,
	input  logic         i_rst,

	// producer side, valid/ready
	input  logic         i_push_valid,
	input  dist_packet_t i_push_packet,
	output logic         o_push_ready,

	// holds the queue, nothing pops while high
	input  logic         i_pause,

	// consumer side, valid only
	output logic         o_pop_valid,
	output dist_packet_t o_pop_packet
);

	localparam int PTR_WIDTH = $clog2(`DIST_QUEUE_DEPTH);
	localparam int CNT_WIDTH = $clog2(`DIST_QUEUE_DEPTH + 1);

	// circular buffer storage
	dist_packet_t         mem [`DIST_QUEUE_DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [CNT_WIDTH-1:0] count;

	logic full;
	logic empty;
	logic push;
	logic pop;

	assign full  = (count == CNT_WIDTH'(`DIST_QUEUE_DEPTH));
	assign empty = (count == '0);

	// ready drops only when every slot is taken
	assign o_push_ready = ~full;
	assign push         = i_push_valid & ~full;

	// drain whenever something is stored and not paused
	assign pop          = ~empty & ~i_pause;
	assign o_pop_valid  = pop;
	assign o_pop_packet = mem[rd_ptr];

	//////////////////////////////////////////////////
	// storage write
	//////////////////////////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (push)
		begin
			mem[wr_ptr] <= i_push_packet;
		end
	end

	//////////////////////////////////////////////////
	// pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (i_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// wrap at depth, depth need not be a power of two
			if (push)
			begin
				wr_ptr <= (wr_ptr == PTR_WIDTH'(`DIST_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop)
			begin
				rd_ptr <= (rd_ptr == PTR_WIDTH'(`DIST_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves count alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== logic/unicast_chain.sv ====
`timescale 1ns/1ps
`include "dist_defines.svh"

module unicast_chain
	import dist_pkg::*;
(
	input  logic                                              CLK,
	input  logic                                              i_rst,

	// packet entering stage 0
	input  logic                                              i_valid,
	input  dist_packet_t                                      i_packet,

	// one pulse and one word per node
	output logic [`DIST_NUM_NODE-1:0]                         o_deliver_valid,
	output logic [`DIST_NUM_NODE-1:0][`DIST_DATA_WIDTH-1:0]   o_deliver_data
);

	// forwarding registers between stages, entry k feeds stage k+1
	logic                        fwd_valid [`DIST_NUM_NODE-1];
	dest_t                       fwd_dest  [`DIST_NUM_NODE-1];
	logic [`DIST_DATA_WIDTH-1:0] fwd_data  [`DIST_NUM_NODE-1];

	// delivery registers, one per node
	logic                        dlv_valid [`DIST_NUM_NODE];
	logic [`DIST_DATA_WIDTH-1:0] dlv_data  [`DIST_NUM_NODE];

	//////////////////////////////////////////////////
	// stages
	//////////////////////////////////////////////////

	genvar k;
	generate
		for (k = 0; k < `DIST_NUM_NODE; k = k + 1)
		begin : g_stage
			// what this stage sees in the current cycle
			logic                        stg_valid;
			dest_t                       stg_dest;
			logic [`DIST_DATA_WIDTH-1:0] stg_data;
			logic                        hit;

			// stage 0 takes the queue output directly
			if (k == 0)
			begin : g_head
				assign stg_valid = i_valid;
				assign stg_dest  = i_packet.dest;
				assign stg_data  = i_packet.data;
			end
			else
			begin : g_body
				assign stg_valid = fwd_valid[k-1];
				assign stg_dest  = fwd_dest[k-1];
				assign stg_data  = fwd_data[k-1];
			end

			// tag names this node
			assign hit = stg_valid & (stg_dest == dest_t'(k));

			// delivery register, zero word when nothing lands here
			always_ff @(posedge CLK)
			begin
				if (i_rst)
				begin
					dlv_valid[k] <= 1'b0;
					dlv_data[k]  <= '0;
				end
				else
				begin
					dlv_valid[k] <= hit;
					dlv_data[k]  <= hit ? stg_data : '0;
				end
			end

			// one hop further, last stage has nobody to forward to
			if (k < `DIST_NUM_NODE - 1)
			begin : g_fwd
				always_ff @(posedge CLK)
				begin
					if (i_rst)
					begin
						fwd_valid[k] <= 1'b0;
						fwd_dest[k]  <= '0;
						fwd_data[k]  <= '0;
					end
					else
					begin
						fwd_valid[k] <= stg_valid;
						fwd_dest[k]  <= stg_dest;
						fwd_data[k]  <= stg_data;
					end
				end
			end
		end
	endgenerate

	// gather per-node registers onto the output buses
	always_comb
	begin
		for (int n = 0; n < `DIST_NUM_NODE; n++)
		begin
			o_deliver_valid[n] = dlv_valid[n];
			o_deliver_data[n]  = dlv_data[n];
		end
	end

endmodule

// ==== logic/pe_accumulator.sv ====
`timescale 1ns/1ps
`include "dist_defines.svh"

module pe_accumulator
(
	input  logic                        CLK,
	input  logic                        i_rst,

	// delivered word from the chain
	input  logic                        i_valid,
	input  logic [`DIST_DATA_WIDTH-1:0] i_data,

	// drop the running total
	input  logic                        i_clear,

	output logic [`DIST_SUM_WIDTH-1:0]  o_sum
);

	logic [`DIST_SUM_WIDTH-1:0] sum;
	logic [`DIST_SUM_WIDTH-1:0] word;

	// zero-extend the word to sum width
	assign word  = `DIST_SUM_WIDTH'(i_data);
	assign o_sum = sum;

	always_ff @(posedge CLK)
	begin
		if (i_rst)
		begin
			sum <= '0;
		end
		else if (i_clear)
		begin
			// a word landing with the clear starts the new total
			sum <= i_valid ? word : '0;
		end
		else if (i_valid)
		begin
			// wraps at sum width
			sum <= sum + word;
		end
	end

endmodule

// ==== logic/dist_top.sv ====
`timescale 1ns/1ps
`include "dist_defines.svh"

module dist_top
	import dist_pkg::*;
(
	input  logic                                            CLK,
	input  logic                                            i_rst,

	// packet source, valid/ready
	input  logic                                            i_in_valid,
	input  dest_t                                           i_in_dest,
	input  logic [`DIST_DATA_WIDTH-1:0]                     i_in_data,
	output logic                                            o_in_ready,

	// flow and sum control
	input  logic                                            i_pause,
	input  logic                                            i_clear,

	// delivery pulses and per-PE totals
	output logic [`DIST_NUM_NODE-1:0]                       o_deliver_valid,
	output logic [`DIST_NUM_NODE-1:0][`DIST_SUM_WIDTH-1:0]  o_pe_sum
);

	dist_packet_t                                       in_packet;
	logic                                               pop_valid;
	dist_packet_t                                       pop_packet;
	logic [`DIST_NUM_NODE-1:0]                          deliver_valid;
	logic [`DIST_NUM_NODE-1:0][`DIST_DATA_WIDTH-1:0]    deliver_data;

	// tag and word travel together from here on
	assign in_packet = '{dest: i_in_dest, data: i_in_data};

	assign o_deliver_valid = deliver_valid;

	//////////////////////////////////////////////////
	// input FIFO
	//////////////////////////////////////////////////

	packet_queue packet_queue_inst
	(
		.CLK           (CLK),
		.i_rst         (i_rst),
		.i_push_valid  (i_in_valid),
		.i_push_packet (in_packet),
		.o_push_ready  (o_in_ready),
		.i_pause       (i_pause),
		.o_pop_valid   (pop_valid),
		.o_pop_packet  (pop_packet)
	);

	//////////////////////////////////////////////////
	// unicast chain
	//////////////////////////////////////////////////

	unicast_chain unicast_chain_inst
	(
		.CLK             (CLK),
		.i_rst           (i_rst),
		.i_valid         (pop_valid),
		.i_packet        (pop_packet),
		.o_deliver_valid (deliver_valid),
		.o_deliver_data  (deliver_data)
	);

	//////////////////////////////////////////////////
	// PE accumulators
	//////////////////////////////////////////////////

	genvar p;
	generate
		for (p = 0; p < `DIST_NUM_NODE; p = p + 1)
		begin : g_pe
			pe_accumulator pe_accumulator_inst
			(
				.CLK     (CLK),
				.i_rst   (i_rst),
				.i_valid (deliver_valid[p]),
				.i_data  (deliver_data[p]),
				.i_clear (i_clear),
				.o_sum   (o_pe_sum[p])
			);
		end
	endgenerate

endmodule

// ==== testbench/dist_top_properties.sv ====
`timescale 1ns/1ps
`include "dist_defines.svh"

module dist_top_properties
	import dist_pkg::*;
(
	input logic                      CLK,
	input logic                      i_rst,
	input logic                      i_in_valid,
	input logic                      o_in_ready,
	input logic                      pop_valid,
	input dist_packet_t              pop_packet,
	input logic [`DIST_NUM_NODE-1:0] deliver_valid
);

	// queue fill level rebuilt from the handshakes
	int occupancy;

	// failed assertions so far
	int assert_errors = 0;

	always @(posedge CLK)
	begin
		if (i_rst)
		begin
			occupancy <= 0;
		end
		else
		begin
			occupancy <= occupancy + int'(i_in_valid && o_in_ready) - int'(pop_valid);
		end
	end

	//////////////////////////////////////////////////
	// queue
	//////////////////////////////////////////////////

	// full queue takes nothing in
	assert property (@(posedge CLK) disable iff (i_rst)
		(occupancy >= `DIST_QUEUE_DEPTH) |-> !(i_in_valid && o_in_ready))
	else
	begin
		$error("push accepted while the queue was full");
		assert_errors++;
	end

	//////////////////////////////////////////////////
	// chain
	//////////////////////////////////////////////////

	// delivery at node k traces back to a pop tagged k, k+1 cycles before
	genvar k;
	generate
		for (k = 0; k < `DIST_NUM_NODE; k = k + 1)
		begin : g_node
			assert property (@(posedge CLK) disable iff (i_rst)
				deliver_valid[k] |-> $past(pop_valid && (pop_packet.dest == dest_t'(k)), k + 1))
			else
			begin
				$error("node %0d delivered without a matching pop", k);
				assert_errors++;
			end
		end
	endgenerate

	// nothing delivered right out of reset
	assert property (@(posedge CLK) $fell(i_rst) |-> (deliver_valid == '0))
	else
	begin
		$error("delivery pulse in the first cycle after reset");
		assert_errors++;
	end

endmodule

// ==== testbench/tb_dist_top.sv ====
`timescale 1ns/1ps
`include "dist_defines.svh"

module tb_dist_top
	import dist_pkg::*;
();

	localparam int NUM_TESTS = 5;
	localparam int MAX_PKT   = 12;

	logic                                           CLK = 1'b0;
	logic                                           i_rst;
	logic                                           i_in_valid;
	dest_t                                          i_in_dest;
	logic [`DIST_DATA_WIDTH-1:0]                    i_in_data;
	logic                                           o_in_ready;
	logic                                           i_pause;
	logic                                           i_clear;
	logic [`DIST_NUM_NODE-1:0]                      o_deliver_valid;
	logic [`DIST_NUM_NODE-1:0][`DIST_SUM_WIDTH-1:0] o_pe_sum;

	//////////////////////////////////////////////////
	// stimulus table, packets are {tag, word}
	//////////////////////////////////////////////////

	string       test_name  [NUM_TESTS] = '{"unicast", "back_to_back", "pause", "clear", "random"};
	int          pkt_count  [NUM_TESTS] = '{8, 12, 6, 6, 40};
	bit          rand_mode  [NUM_TESTS] = '{0, 0, 0, 0, 1};
	int          pause_len  [NUM_TESTS] = '{0, 0, 12, 0, 0};
	bit          clear_flag [NUM_TESTS] = '{0, 0, 0, 1, 0};
	logic [18:0] pkt_table  [NUM_TESTS][MAX_PKT] = '{
		'{'h01111, 'h12222, 'h23333, 'h34444, 'h45555, 'h56666, 'h67777, 'h78888, 0, 0, 0, 0},
		'{'h70100, 'h00200, 'h30300, 'h70400, 'h10500, 'h70600,
		  'h00700, 'h50800, 'h20900, 'h60a00, 'h40b00, 'h70c00},
		'{'h2aaaa, 'h61234, 'h2beef, 'h00001, 'h7ffff, 'h3c0de, 0, 0, 0, 0, 0, 0},
		'{'h3abcd, 'h3ffff, 'h0ffff, 'h51234, 'h5fedc, 'h2beef, 0, 0, 0, 0, 0, 0},
		'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}
	};

	// reference model and bookkeeping
	logic [`DIST_SUM_WIDTH-1:0] model_sum [`DIST_NUM_NODE];
	int model_pulses [`DIST_NUM_NODE];
	int seen_pulses  [`DIST_NUM_NODE];
	int accepted      = 0;
	int delivered     = 0;
	int checks_failed = 0;
	int tests_failed  = 0;
	int cycles        = 0;
	int cycle_limit   = 0;

	dist_top dist_top_inst
	(
		.CLK             (CLK),
		.i_rst           (i_rst),
		.i_in_valid      (i_in_valid),
		.i_in_dest       (i_in_dest),
		.i_in_data       (i_in_data),
		.o_in_ready      (o_in_ready),
		.i_pause         (i_pause),
		.i_clear         (i_clear),
		.o_deliver_valid (o_deliver_valid),
		.o_pe_sum        (o_pe_sum)
	);

	bind dist_top dist_top_properties dist_top_properties_inst
	(
		.CLK           (CLK),
		.i_rst         (i_rst),
		.i_in_valid    (i_in_valid),
		.o_in_ready    (o_in_ready),
		.pop_valid     (pop_valid),
		.pop_packet    (pop_packet),
		.deliver_valid (deliver_valid)
	);

	// 40 ns period
	always #20 CLK = ~CLK;

	// run limit
	always @(posedge CLK)
	begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("timeout after %0d cycles, packets never drained from the chain", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	// count delivery pulses per node
	always @(negedge CLK)
	begin
		if (!i_rst)
		begin
			for (int n = 0; n < `DIST_NUM_NODE; n++)
			begin
				if (o_deliver_valid[n])
				begin
					seen_pulses[n] = seen_pulses[n] + 1;
					delivered = delivered + 1;
				end
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			checks_failed++;
			$display("error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	// offer one row's packets, holding pause for its first cycles
	task automatic send_row(input int t);
		logic [18:0] pkts [$];
		int idx;
		int cyc;
		idx = 0;
		cyc = 0;
		for (int i = 0; i < pkt_count[t]; i++)
		begin
			if (rand_mode[t])
			begin
				// high bit set so words are large
				pkts.push_back({3'($urandom_range(0, 7)), 16'($urandom) | 16'h8000});
			end
			else
			begin
				pkts.push_back(pkt_table[t][i]);
			end
		end
		while (idx < pkts.size() || cyc < pause_len[t])
		begin
			@(posedge CLK);
			i_pause    <= (cyc < pause_len[t]);
			i_in_valid <= (idx < pkts.size());
			if (idx < pkts.size())
			begin
				i_in_dest <= pkts[idx][18:16];
				i_in_data <= pkts[idx][15:0];
			end
			@(negedge CLK);
			if (i_pause)
			begin
				// held queue, so the drained chain stays quiet
				check_value("o_deliver_valid", 0, o_deliver_valid);
				// nothing pops, so ready holds until every slot is taken
				check_value("o_in_ready", (idx < `DIST_QUEUE_DEPTH), o_in_ready);
			end
			if (i_in_valid && o_in_ready)
			begin
				model_sum[pkts[idx][18:16]] += `DIST_SUM_WIDTH'(pkts[idx][15:0]);
				model_pulses[pkts[idx][18:16]]++;
				accepted++;
				idx++;
			end
			cyc++;
		end
		@(posedge CLK);
		i_in_valid <= 1'b0;
		i_pause    <= 1'b0;
	endtask

	initial
	begin
		int total;
		int errs_before;
		int assert_fails;
		void'($urandom(55));
		total = 0;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			total += pkt_count[t] * (`DIST_NUM_NODE + `DIST_QUEUE_DEPTH + 2) + pause_len[t];
		end
		cycle_limit = total + 200;
		i_rst      <= 1'b1;
		i_in_valid <= 1'b0;
		i_in_dest  <= '0;
		i_in_data  <= '0;
		i_pause    <= 1'b0;
		i_clear    <= 1'b0;
		for (int n = 0; n < `DIST_NUM_NODE; n++)
		begin
			model_sum[n] = '0;
		end
		repeat (10) @(posedge CLK);
		i_rst <= 1'b0;

		// state straight out of reset
		@(negedge CLK);
		check_value("o_in_ready", 1, o_in_ready);
		check_value("o_deliver_valid", 0, o_deliver_valid);
		for (int n = 0; n < `DIST_NUM_NODE; n++)
		begin
			check_value($sformatf("o_pe_sum[%0d]", n), 0, o_pe_sum[n]);
		end
		$display("test reset: %s", (checks_failed == 0) ? "ok" : "mismatch");
		tests_failed += (checks_failed != 0);

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			errs_before = checks_failed;
			for (int n = 0; n < `DIST_NUM_NODE; n++)
			begin
				seen_pulses[n]  = 0;
				model_pulses[n] = 0;
			end
			if (clear_flag[t])
			begin
				@(posedge CLK);
				i_clear <= 1'b1;
				@(posedge CLK);
				i_clear <= 1'b0;
				@(negedge CLK);
				for (int n = 0; n < `DIST_NUM_NODE; n++)
				begin
					model_sum[n] = '0;
					check_value($sformatf("o_pe_sum[%0d]", n), 0, o_pe_sum[n]);
				end
			end
			send_row(t);
			// drained when every accepted packet has pulsed out
			while (accepted != delivered)
			begin
				@(posedge CLK);
			end
			@(negedge CLK);
			for (int n = 0; n < `DIST_NUM_NODE; n++)
			begin
				check_value($sformatf("o_pe_sum[%0d]", n), model_sum[n], o_pe_sum[n]);
				check_value($sformatf("o_deliver_valid[%0d] pulses", n), model_pulses[n],
					seen_pulses[n]);
			end
			$display("test %s: %0d mismatches", test_name[t], checks_failed - errs_before);
			tests_failed += (checks_failed != errs_before);
		end

		assert_fails = dist_top_inst.dist_top_properties_inst.assert_errors;
		$display("tests run %0d, tests failed %0d, checks failed %0d, assertion failures %0d",
			NUM_TESTS + 1, tests_failed, checks_failed, assert_fails);
		if (checks_failed == 0 && assert_fails == 0)
		begin
			$display("Regression passed");
		end
		else
		begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+logic
logic/dist_pkg.sv
logic/packet_queue.sv
logic/unicast_chain.sv
logic/pe_accumulator.sv
logic/dist_top.sv
testbench/dist_top_properties.sv
testbench/tb_dist_top.sv
